// ==== Makefile ====
# Verilator build and run for the memory subsystem testbench
SIM      ?= verilator
TOP      ?= memSubsystemTb
FLAGS    ?= --binary --timing --assert
OBJDIR   ?= obj_dir
FILELIST ?= sources.f
PASSTEXT ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== logic/dCache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dCache #(
  parameter int dCacheIndexWidth = 3
) (
  input  logic                            clkIn,
  input  logic                            resetIn,
  input  logic                            readyIn,
  input  logic                            clearIn,
  input  logic [1:0]                      accessType,
  input  logic                            readWriteIn,   // 1 read, 0 write
  input  logic [31:0]                     dataAddrIn,
  input  logic [31:0]                     dataIn,
  input  logic                            dFillValid,
  input  logic                            writeBackDone,
  input  logic [31-memPkg::blockWidth:0]  fillTag,
  input  logic [memPkg::blockBytes*8-1:0] fillBlock,
  input  logic                            ioReadValid,
  input  logic [31:0]                     ioReadData,
  input  logic                            ioWriteDone,
  output logic                            dMiss,
  output logic                            dMissRead,
  output logic [31-memPkg::blockWidth:0]  missTag,
  output logic [memPkg::blockBytes*8-1:0] victimBlock,
  output logic                            dataOutValid,
  output logic [31:0]                     dataOut,
  output logic                            dataWriteSuc
);

  localparam int lineCount = 2 ** dCacheIndexWidth;
  localparam int tagWidth  = 32 - memPkg::blockWidth - dCacheIndexWidth;

  localparam logic [1:0] sIdle      = 2'd0;
  localparam logic [1:0] sLookup    = 2'd1;
  localparam logic [1:0] sWriteBack = 2'd2;
  localparam logic [1:0] sRead      = 2'd3;

  logic [memPkg::blockBytes*8-1:0] lineData [lineCount];
  logic [tagWidth-1:0]             lineTag  [lineCount];
  logic [lineCount-1:0]            lineValid;
  logic [lineCount-1:0]            lineDirty;

  logic [1:0]        state;
  logic              reqLive;     // request still owed an answer
  logic              reqWrite;
  logic [1:0]        reqType;
  memPkg::blockAddrU reqAddr;
  logic [31:0]       reqData;
  logic              loadDone;
  logic              storeDone;
  logic [31:0]       loadData;

  logic [dCacheIndexWidth-1:0] reqIdx;
  logic [dCacheIndexWidth-1:0] missIdx;
  logic [tagWidth-1:0]         reqTag;
  logic                        newReq;
  logic                        liveReq;
  logic                        hit;
  logic                        victimDirty;
  logic                        lookupHit;
  logic                        lookupMiss;
  logic                        fillMatch;
  logic [6:0]                  wordBase;
  logic [4:0]                  byteShift;
  logic [31:0]                 hitWord;
  logic [31:0]                 sizeMask;
  logic [31:0]                 storeMask;
  logic [31:0]                 mergedWord;

  // uncached window is left to the controller
  assign newReq  = accessType != memPkg::accessNone &&
                   dataAddrIn[17:16] != memPkg::ioWindowBits;
  assign reqIdx  = reqAddr.split.blockTag[dCacheIndexWidth-1:0];
  assign reqTag  = reqAddr.split.blockTag[31-memPkg::blockWidth:dCacheIndexWidth];
  assign missIdx = missTag[dCacheIndexWidth-1:0];
  assign liveReq = reqLive && !(clearIn && !reqWrite); // loads only

  assign hit         = lineValid[reqIdx] && lineTag[reqIdx] == reqTag;
  assign victimDirty = lineValid[reqIdx] && lineDirty[reqIdx];
  assign lookupHit   = state == sLookup && liveReq && hit;
  assign lookupMiss  = state == sLookup && liveReq && !hit;
  assign fillMatch   = state == sRead && dFillValid && fillTag == missTag;

  assign wordBase  = {reqAddr.split.byteOffset[3:2], 5'b0};
  assign byteShift = {reqAddr.split.byteOffset[1:0], 3'b0};
  assign hitWord   = lineData[reqIdx][wordBase +: 32];

  always_comb begin
    case (reqType)
      memPkg::accessByte: sizeMask = 32'h0000_00ff;
      memPkg::accessHalf: sizeMask = 32'h0000_ffff;
      default:            sizeMask = 32'hffff_ffff;
    endcase
  end

  assign storeMask  = sizeMask << byteShift;
  assign mergedWord = (hitWord & ~storeMask) | ((reqData << byteShift) & storeMask);

  assign dMiss        = state == sWriteBack || state == sRead;
  assign dMissRead    = state == sRead;
  assign victimBlock  = lineData[missIdx];
  assign dataOutValid = loadDone || ioReadValid;   // uncached answers pass through
  assign dataOut      = ioReadValid ? ioReadData : loadData;
  assign dataWriteSuc = storeDone || ioWriteDone;

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      state     <= sIdle;
      reqLive   <= 1'b0;
      loadDone  <= 1'b0;
      storeDone <= 1'b0;
      lineValid <= '0;
      lineDirty <= '0;
    end else if (readyIn) begin
      loadDone  <= lookupHit && !reqWrite;
      storeDone <= lookupHit && reqWrite;
      reqLive   <= liveReq;
      case (state)
        sLookup: begin
          if (lookupHit) begin
            state   <= sIdle;
            reqLive <= 1'b0;
            if (reqWrite) begin
              lineDirty[reqIdx] <= 1'b1;
            end
          end else if (lookupMiss) begin
            state <= victimDirty ? sWriteBack : sRead;
          end else begin
            state <= sIdle;   // load dropped by clearIn
          end
        end
        sWriteBack: begin
          if (writeBackDone) begin
            lineDirty[missIdx] <= 1'b0;
            state              <= sLookup; // look again, line is clean now
          end
        end
        sRead: begin
          if (fillMatch) begin
            lineValid[missIdx] <= 1'b1;
            lineDirty[missIdx] <= 1'b0;
            state              <= sLookup;
          end
        end
        default: begin
        end
      endcase
      if (newReq) begin
        reqLive <= 1'b1;
        if (state == sIdle) begin
          state <= sLookup;
        end
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (readyIn) begin
      if (newReq) begin
        reqAddr  <= dataAddrIn;
        reqType  <= accessType;
        reqWrite <= !readWriteIn;
        reqData  <= dataIn;
      end
      if (lookupHit) begin
        loadData <= (hitWord >> byteShift) & sizeMask; // zero-extended
        if (reqWrite) begin
          lineData[reqIdx][wordBase +: 32] <= mergedWord;
        end
      end
      if (lookupMiss) begin
        missTag <= victimDirty ? {lineTag[reqIdx], reqIdx} : reqAddr.split.blockTag;
      end
      if (fillMatch) begin
        lineData[missIdx] <= fillBlock;
        lineTag[missIdx]  <= missTag[31-memPkg::blockWidth:dCacheIndexWidth];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/iCache.sv ====
`timescale 1ns/1ps
`default_nettype none

module iCache #(
  parameter int iCacheIndexWidth = 4
) (
  input  logic                            clkIn,
  input  logic                            resetIn,
  input  logic                            readyIn,
  input  logic [31:0]                     instrAddrIn,
  input  logic                            iFillValid,
  input  logic [31-memPkg::blockWidth:0]  fillTag,
  input  logic [memPkg::blockBytes*8-1:0] fillBlock,
  output logic                            iMiss,
  output logic                            instrOutValid,
  output logic [31:0]                     instrOut
);

  localparam int lineCount = 2 ** iCacheIndexWidth;
  localparam int tagWidth  = 32 - memPkg::blockWidth - iCacheIndexWidth;

  logic [memPkg::blockBytes*8-1:0] lineData [lineCount];
  logic [tagWidth-1:0]             lineTag  [lineCount];
  logic [lineCount-1:0]            lineValid;

  memPkg::blockAddrU           fetchAddr;
  logic [iCacheIndexWidth-1:0] fetchIdx;
  logic [tagWidth-1:0]         fetchTag;
  logic [iCacheIndexWidth-1:0] fillIdx;
  logic                        fillMatch;
  logic                        hit;
  logic [31:0]                 hitWord;

  assign fetchAddr = instrAddrIn;
  assign fetchIdx  = fetchAddr.split.blockTag[iCacheIndexWidth-1:0];
  assign fetchTag  = fetchAddr.split.blockTag[31-memPkg::blockWidth:iCacheIndexWidth];
  assign fillIdx   = fillTag[iCacheIndexWidth-1:0];
  assign fillMatch = iFillValid && fillTag == fetchAddr.split.blockTag; // our outstanding miss
  assign hit       = lineValid[fetchIdx] && lineTag[fetchIdx] == fetchTag;

  // little-endian word at the word offset
  assign hitWord = lineData[fetchIdx][{fetchAddr.split.byteOffset[3:2], 5'b0} +: 32];

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      lineValid     <= '0;
      iMiss         <= 1'b0;
      instrOutValid <= 1'b0;
    end else if (readyIn) begin
      iMiss         <= !hit && !iFillValid; // quiet while the block lands
      instrOutValid <= hit;
      if (fillMatch) begin
        lineValid[fillIdx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clkIn) begin
    if (readyIn) begin
      instrOut <= hitWord;
      if (fillMatch) begin
        lineData[fillIdx] <= fillBlock;
        lineTag[fillIdx]  <= fillTag[31-memPkg::blockWidth:iCacheIndexWidth];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/memController.sv ====
`timescale 1ns/1ps
`default_nettype none

module memController (
  input  logic                            clkIn,
  input  logic                            resetIn,
  input  logic                            readyIn,
  input  logic [7:0]                      memIn,
  input  logic                            iMiss,
  input  logic [31:0]                     instrAddrIn,
  input  logic                            dMiss,
  input  logic                            dMissRead,
  input  logic [31-memPkg::blockWidth:0]  missTag,
  input  logic [memPkg::blockBytes*8-1:0] victimBlock,
  input  logic [1:0]                      accessType,
  input  logic                            readWriteIn,   // 1 read, 0 write
  input  logic [31:0]                     dataAddrIn,
  input  logic [31:0]                     dataIn,
  output logic [31:0]                     memAddr,
  output logic [7:0]                      memOut,
  output logic                            readWriteOut,  // 1 write
  output logic [31-memPkg::blockWidth:0]  fillTag,
  output logic [memPkg::blockBytes*8-1:0] fillBlock,
  output logic                            iFillValid,
  output logic                            dFillValid,
  output logic                            writeBackDone,
  output logic                            ioReadValid,
  output logic [31:0]                     ioReadData,
  output logic                            ioWriteDone
);

  localparam int blockBits = memPkg::blockBytes * 8;

  localparam logic [1:0] sIdle = 2'd0;
  localparam logic [1:0] sRun  = 2'd1;
  localparam logic [1:0] sDone = 2'd2;

  localparam logic [2:0] opIFill     = 3'd0;
  localparam logic [2:0] opDFill     = 3'd1;
  localparam logic [2:0] opWriteBack = 3'd2;
  localparam logic [2:0] opIoRead    = 3'd3;
  localparam logic [2:0] opIoWrite   = 3'd4;

  logic [1:0]                     state;
  logic [2:0]                     opKind;
  logic [4:0]                     count;      // bytes sequenced so far
  logic [4:0]                     byteCount;  // transfer length
  logic [4:0]                     prevCount;
  logic [4:0]                     nextCount;
  logic [blockBits-1:0]           buffer;
  logic [31-memPkg::blockWidth:0] tagReg;
  logic                           opWrite;

  // uncached request, caught from the strobe
  logic                           ioStrobe;
  logic                           ioPend;
  logic                           ioWrite;
  logic [1:0]                     ioType;
  logic [31:0]                    ioAddr;
  logic [31:0]                    ioData;
  logic [4:0]                     ioBytes;

  memPkg::blockAddrU              instrAddrU;
  memPkg::blockAddrU              blockBase;

  assign ioStrobe = accessType != memPkg::accessNone &&
                    dataAddrIn[17:16] == memPkg::ioWindowBits;
  assign opWrite   = opKind == opWriteBack || opKind == opIoWrite;
  assign prevCount = count - 5'd1;
  assign nextCount = count + 5'd1;

  always_comb begin
    case (ioType)
      memPkg::accessHalf: ioBytes = 5'd2;
      memPkg::accessWord: ioBytes = 5'd4;
      default:            ioBytes = 5'd1;
    endcase
  end

  // block start address, data cache ahead of instruction cache
  assign instrAddrU = instrAddrIn;
  always_comb begin
    blockBase.split.blockTag   = dMiss ? missTag : instrAddrU.split.blockTag;
    blockBase.split.byteOffset = '0;
  end

  assign iFillValid    = state == sDone && opKind == opIFill;
  assign dFillValid    = state == sDone && opKind == opDFill;
  assign writeBackDone = state == sDone && opKind == opWriteBack;
  assign ioReadValid   = state == sDone && opKind == opIoRead;
  assign ioWriteDone   = state == sDone && opKind == opIoWrite;
  assign fillTag       = tagReg;
  assign fillBlock     = buffer;
  assign ioReadData    = buffer[31:0];

  always_ff @(posedge clkIn) begin
    if (resetIn) begin
      state        <= sIdle;
      ioPend       <= 1'b0;
      readWriteOut <= 1'b0;
      memAddr      <= '0;
    end else if (readyIn) begin
      case (state)
        sIdle: begin
          count <= '0;
          if (ioPend) begin
            state        <= sRun;
            ioPend       <= 1'b0;
            opKind       <= ioWrite ? opIoWrite : opIoRead;
            byteCount    <= ioBytes;
            memAddr      <= ioAddr;
            buffer       <= {{(blockBits-32){1'b0}}, ioData}; // zero for loads
            memOut       <= ioData[7:0];
            readWriteOut <= ioWrite;
          end else if (dMiss || iMiss) begin
            state     <= sRun;
            opKind    <= !dMiss ? opIFill : (dMissRead ? opDFill : opWriteBack);
            byteCount <= 5'(memPkg::blockBytes);
            tagReg    <= blockBase.split.blockTag;
            memAddr   <= blockBase.flat;
            if (dMiss && !dMissRead) begin
              buffer       <= victimBlock;
              memOut       <= victimBlock[7:0];
              readWriteOut <= 1'b1;
            end
          end
        end
        sRun: begin
          count <= nextCount;
          if (!opWrite) begin
            // byte of the previous address arrives now
            if (count != 5'd0) begin
              buffer[{prevCount[3:0], 3'b0} +: 8] <= memIn;
            end
            if (count == byteCount) begin
              state <= sDone;
            end else if (nextCount != byteCount) begin
              memAddr <= memAddr + 32'd1;
            end
          end else if (nextCount == byteCount) begin
            readWriteOut <= 1'b0;  // last byte written at this edge
            state        <= sDone;
          end else begin
            memAddr <= memAddr + 32'd1;
            memOut  <= buffer[{nextCount[3:0], 3'b0} +: 8];
          end
        end
        default: begin
          state <= sIdle;   // one-cycle done pulse
        end
      endcase
      if (ioStrobe) begin
        ioPend  <= 1'b1;
        ioAddr  <= dataAddrIn;
        ioType  <= accessType;
        ioWrite <= !readWriteIn;
        ioData  <= readWriteIn ? 32'd0 : dataIn;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/memPkg.sv ====
`default_nettype none

package memPkg;

  localparam int blockWidth = 4;               // byte-offset bits in a block
  localparam int blockBytes = 2 ** blockWidth; // bytes per block

  // access-type codes on accessType
  localparam logic [1:0] accessNone = 2'd0;
  localparam logic [1:0] accessByte = 2'd1;
  localparam logic [1:0] accessHalf = 2'd2;
  localparam logic [1:0] accessWord = 2'd3;

  localparam logic [1:0] ioWindowBits = 2'b11; // addr[17:16] of uncached space

  // a byte address, flat or split at the block boundary
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [31-blockWidth:0] blockTag;
      logic [blockWidth-1:0]  byteOffset;
    } split;
  } blockAddrU;

endpackage

`default_nettype wire

// ==== logic/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
  parameter int iCacheIndexWidth = 4,
  parameter int dCacheIndexWidth = 3
) (
  input  logic        clkIn,
  input  logic        resetIn,
  input  logic        readyIn,       // global stall when low
  input  logic        clearIn,       // drops a pending load
  input  logic [31:0] instrAddrIn,
  input  logic [1:0]  accessType,
  input  logic        readWriteIn,   // 1 read, 0 write
  input  logic [31:0] dataAddrIn,
  input  logic [31:0] dataIn,
  input  logic [7:0]  memIn,
  output logic [31:0] memAddr,
  output logic [7:0]  memOut,
  output logic        readWriteOut,  // 1 write
  output logic        instrOutValid,
  output logic [31:0] instrOut,
  output logic        dataOutValid,
  output logic [31:0] dataOut,
  output logic        dataWriteSuc
);

  logic                            iMiss;
  logic                            iFillValid;
  logic                            dMiss;
  logic                            dMissRead;
  logic [31-memPkg::blockWidth:0]  missTag;
  logic [memPkg::blockBytes*8-1:0] victimBlock;
  logic                            dFillValid;
  logic                            writeBackDone;
  logic [31-memPkg::blockWidth:0]  fillTag;
  logic [memPkg::blockBytes*8-1:0] fillBlock;
  logic                            ioReadValid;
  logic [31:0]                     ioReadData;
  logic                            ioWriteDone;

  iCache #(
    .iCacheIndexWidth (iCacheIndexWidth)
  ) i_iCache (
    .clkIn         (clkIn),
    .resetIn       (resetIn),
    .readyIn       (readyIn),
    .instrAddrIn   (instrAddrIn),
    .iFillValid    (iFillValid),
    .fillTag       (fillTag),
    .fillBlock     (fillBlock),
    .iMiss         (iMiss),
    .instrOutValid (instrOutValid),
    .instrOut      (instrOut)
  );

  dCache #(
    .dCacheIndexWidth (dCacheIndexWidth)
  ) i_dCache (
    .clkIn         (clkIn),
    .resetIn       (resetIn),
    .readyIn       (readyIn),
    .clearIn       (clearIn),
    .accessType    (accessType),
    .readWriteIn   (readWriteIn),
    .dataAddrIn    (dataAddrIn),
    .dataIn        (dataIn),
    .dFillValid    (dFillValid),
    .writeBackDone (writeBackDone),
    .fillTag       (fillTag),
    .fillBlock     (fillBlock),
    .ioReadValid   (ioReadValid),
    .ioReadData    (ioReadData),
    .ioWriteDone   (ioWriteDone),
    .dMiss         (dMiss),
    .dMissRead     (dMissRead),
    .missTag       (missTag),
    .victimBlock   (victimBlock),
    .dataOutValid  (dataOutValid),
    .dataOut       (dataOut),
    .dataWriteSuc  (dataWriteSuc)
  );

  memController i_memController (
    .clkIn         (clkIn),
    .resetIn       (resetIn),
    .readyIn       (readyIn),
    .memIn         (memIn),
    .iMiss         (iMiss),
    .instrAddrIn   (instrAddrIn),
    .dMiss         (dMiss),
    .dMissRead     (dMissRead),
    .missTag       (missTag),
    .victimBlock   (victimBlock),
    .accessType    (accessType),
    .readWriteIn   (readWriteIn),
    .dataAddrIn    (dataAddrIn),
    .dataIn        (dataIn),
    .memAddr       (memAddr),
    .memOut        (memOut),
    .readWriteOut  (readWriteOut),
    .fillTag       (fillTag),
    .fillBlock     (fillBlock),
    .iFillValid    (iFillValid),
    .dFillValid    (dFillValid),
    .writeBackDone (writeBackDone),
    .ioReadValid   (ioReadValid),
    .ioReadData    (ioReadData),
    .ioWriteDone   (ioWriteDone)
  );

endmodule

`default_nettype wire

// ==== sources.f ====
logic/memPkg.sv
logic/iCache.sv
logic/dCache.sv
logic/memController.sv
logic/memSubsystem.sv
tb/clockGen.sv
tb/memSubsystem_properties.sv
tb/memSubsystemTb.sv

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int periodNs    = 40,
  parameter int resetCycles = 5
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(periodNs / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clock);
    #2;
    reset = 1'b0; // released just after an edge, like the other inputs
  end

endmodule

`default_nettype wire

// ==== tb/memSubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

  localparam int ramBytes   = 262144;
  localparam int pulseLimit = 400;    // cycles allowed for one answer
  localparam int kFetch     = 0;
  localparam int kFetchHit  = 1;
  localparam int kLoad      = 2;
  localparam int kStore     = 3;
  localparam int kRamCheck  = 4;
  localparam int kClearLoad = 5;
  localparam int kStallLoad = 6;

  typedef struct {
    int          kind;
    logic [31:0] addr;
    logic [1:0]  at;
    logic [31:0] wdata;
    logic [31:0] expected;
  } entryT;

  logic        clkIn;
  logic        resetIn;
  logic        readyIn;
  logic        clearIn;
  logic [31:0] instrAddrIn;
  logic [1:0]  accessType;
  logic        readWriteIn;
  logic [31:0] dataAddrIn;
  logic [31:0] dataIn;
  logic [7:0]  memIn;
  logic [31:0] memAddr;
  logic [7:0]  memOut;
  logic        readWriteOut;
  logic        instrOutValid;
  logic [31:0] instrOut;
  logic        dataOutValid;
  logic [31:0] dataOut;
  logic        dataWriteSuc;

  logic [7:0] ram    [ramBytes];
  logic [7:0] shadow [ramBytes]; // memory as the program sees it
  entryT      stimTable [$];
  int         errorCount;
  int         checkCount;
  integer     seed;
  bit         tableReady;

  clockGen #(.periodNs(40), .resetCycles(5)) i_clockGen (.clock(clkIn), .reset(resetIn));

  memSubsystem #(
    .iCacheIndexWidth (4),
    .dCacheIndexWidth (3)
  ) i_dut (
    .clkIn (clkIn), .resetIn (resetIn), .readyIn (readyIn), .clearIn (clearIn),
    .instrAddrIn (instrAddrIn), .accessType (accessType), .readWriteIn (readWriteIn),
    .dataAddrIn (dataAddrIn), .dataIn (dataIn), .memIn (memIn), .memAddr (memAddr),
    .memOut (memOut), .readWriteOut (readWriteOut), .instrOutValid (instrOutValid),
    .instrOut (instrOut), .dataOutValid (dataOutValid), .dataOut (dataOut),
    .dataWriteSuc (dataWriteSuc)
  );

  // synchronous RAM, one-cycle read, frozen by the stall like the DUT
  always @(posedge clkIn) begin
    if (readyIn) begin
      if (readWriteOut === 1'b1) begin
        ram[memAddr[17:0]] <= memOut;
      end
      memIn <= ram[memAddr[17:0]];
    end
  end

  function automatic int accessBytes(logic [1:0] at);
    case (at)
      memPkg::accessByte: return 1;
      memPkg::accessHalf: return 2;
      default:            return 4;
    endcase
  endfunction

  function automatic logic [31:0] shadowRead(logic [31:0] addr, logic [1:0] at);
    logic [31:0] w;
    w = '0; // zero-extended
    for (int i = 0; i < accessBytes(at); i++) w[8*i +: 8] = shadow[18'(addr + i)];
    return w;
  endfunction

  task automatic addEntry(int kind, logic [31:0] addr, logic [1:0] at, logic [31:0] wdata);
    entryT e;
    e.kind     = kind;
    e.addr     = addr;
    e.at       = at;
    e.wdata    = wdata;
    e.expected = shadowRead(addr, at);
    if (kind == kStore) begin
      for (int i = 0; i < accessBytes(at); i++) shadow[18'(addr + i)] = wdata[8*i +: 8];
    end
    stimTable.push_back(e);
  endtask

  task automatic checkInstr(logic [31:0] addr, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAILED %0t: fetch at %h returned %h, expected %h", $time, addr, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkLoad(logic [31:0] addr, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAILED %0t: load at %h returned %h, expected %h", $time, addr, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkRamByte(logic [17:0] addr, logic [7:0] got, logic [7:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("FAILED %0t: RAM byte at %h is %h, expected %h", $time, addr, got, exp);
      errorCount++;
    end
  endtask

  task automatic issueData(logic [1:0] at, logic isRead, logic [31:0] addr, logic [31:0] data);
    @(posedge clkIn);
    #2;
    accessType  = at;
    readWriteIn = isRead;
    dataAddrIn  = addr;
    dataIn      = data;
    @(posedge clkIn);
    #2;
    accessType = memPkg::accessNone; // one-cycle strobe
  endtask

  task automatic waitAnswer(input bit wantStore, output bit seen, output logic [31:0] value);
    int n;
    seen  = 1'b0;
    value = '0;
    n     = 0;
    while (!seen && n < pulseLimit) begin
      @(negedge clkIn);
      n++;
      if (wantStore ? dataWriteSuc : dataOutValid) begin
        seen  = 1'b1;
        value = dataOut;
      end
    end
    if (!seen) begin
      $display("no answer from the DUT within %0d cycles at time %0t", pulseLimit, $time);
      errorCount++;
    end
  endtask

  task automatic runEntry(entryT e);
    bit          seen;
    logic [31:0] value;
    int          n;
    logic [17:0] idx;
    case (e.kind)
      kFetch, kFetchHit: begin
        @(posedge clkIn);
        #2;
        instrAddrIn = e.addr;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < pulseLimit) begin
          @(posedge clkIn);   // valid follows the new address one edge later
          @(negedge clkIn);
          n++;
          seen = instrOutValid;
        end
        if (!seen) begin
          $display("instruction fetch at %h never completed", e.addr);
          errorCount++;
        end else begin
          checkInstr(e.addr, instrOut, e.expected);
          if (e.kind == kFetchHit && n != 1) begin
            $display("FAILED %0t: fetch at %h took %0d cycles, expected a hit", $time, e.addr, n);
            errorCount++;
          end
        end
      end
      kStore: begin
        issueData(e.at, 1'b0, e.addr, e.wdata);
        waitAnswer(1'b1, seen, value);
      end
      kRamCheck: begin
        @(negedge clkIn);
        for (int k = 0; k < accessBytes(e.at); k++) begin
          idx = 18'(e.addr + k);
          checkRamByte(idx, ram[idx], e.expected[8*k +: 8]);
        end
      end
      kClearLoad: begin
        issueData(e.at, 1'b1, e.addr, '0);
        repeat (4) @(posedge clkIn);
        #2;
        clearIn = 1'b1;   // lands while the fill runs
        @(posedge clkIn);
        #2;
        clearIn = 1'b0;
        seen = 1'b0;
        for (n = 0; n < 80; n++) begin
          @(negedge clkIn);
          if (dataOutValid) seen = 1'b1;
        end
        checkCount++;
        if (seen) begin
          $display("FAILED %0t: dropped load at %h still answered", $time, e.addr);
          errorCount++;
        end
      end
      default: begin
        issueData(e.at, 1'b1, e.addr, '0);
        if (e.kind == kStallLoad) begin
          repeat (6) @(posedge clkIn);
          #2;
          readyIn = 1'b0;
          repeat (6) @(posedge clkIn);
          #2;
          readyIn = 1'b1;
        end
        waitAnswer(1'b0, seen, value);
        if (seen) checkLoad(e.addr, value, e.expected);
      end
    endcase
  endtask

  initial begin
    logic [7:0] b;
    readyIn     = 1'b1;
    clearIn     = 1'b0;
    instrAddrIn = '0;
    accessType  = memPkg::accessNone;
    readWriteIn = 1'b1;
    dataAddrIn  = '0;
    dataIn      = '0;
    memIn      <= '0;
    errorCount  = 0;
    checkCount  = 0;
    seed        = 83;
    for (int a = 0; a < ramBytes; a++) begin
      b = 8'($random(seed)) ^ 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
      ram[a]   <= b;
      shadow[a] = b;
    end
    addEntry(kFetch,     32'h0000_0100, memPkg::accessWord, '0);
    addEntry(kFetchHit,  32'h0000_0104, memPkg::accessWord, '0);
    addEntry(kFetch,     32'h0000_01c8, memPkg::accessWord, '0);
    addEntry(kLoad,      32'h0000_2000, memPkg::accessWord, '0);
    addEntry(kLoad,      32'h0000_2006, memPkg::accessHalf, '0);
    addEntry(kLoad,      32'h0000_2003, memPkg::accessByte, '0);
    addEntry(kStore,     32'h0000_2012, memPkg::accessHalf, 32'h0000_a5c3);
    addEntry(kLoad,      32'h0000_2010, memPkg::accessWord, '0);
    addEntry(kStore,     32'h0000_2004, memPkg::accessByte, 32'h0000_005c);
    addEntry(kLoad,      32'h0000_2004, memPkg::accessWord, '0);
    addEntry(kLoad,      32'h0000_2084, memPkg::accessWord, '0); // evicts the dirty line
    addEntry(kRamCheck,  32'h0000_2004, memPkg::accessWord, '0);
    addEntry(kStore,     32'h0003_0020, memPkg::accessWord, 32'hdead_beef);
    addEntry(kRamCheck,  32'h0003_0020, memPkg::accessWord, '0);
    addEntry(kStore,     32'h0003_0031, memPkg::accessByte, 32'h0000_0077);
    addEntry(kRamCheck,  32'h0003_0030, memPkg::accessWord, '0);
    addEntry(kLoad,      32'h0003_0020, memPkg::accessWord, '0);
    addEntry(kLoad,      32'h0003_0030, memPkg::accessHalf, '0);
    addEntry(kLoad,      32'h0000_2010, memPkg::accessWord, '0);
    addEntry(kClearLoad, 32'h0000_2400, memPkg::accessWord, '0);
    addEntry(kLoad,      32'h0000_2400, memPkg::accessWord, '0);
    addEntry(kStallLoad, 32'h0000_2500, memPkg::accessWord, '0);
    tableReady = 1'b1;
    wait (resetIn == 1'b0);
    @(negedge clkIn);
    checkCount++;
    if (readWriteOut !== 1'b0 || instrOutValid !== 1'b0 || dataOutValid !== 1'b0 ||
        dataWriteSuc !== 1'b0 || memAddr !== 32'd0) begin
      $display("FAILED %0t: outputs not in their reset state", $time);
      errorCount++;
    end
    foreach (stimTable[i]) runEntry(stimTable[i]);
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog scaled by the table length
  initial begin
    wait (tableReady);
    repeat (stimTable.size() * 200) @(posedge clkIn);
    $display("watchdog expired before the table finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/memSubsystem_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystemProperties (
  input logic        clkIn,
  input logic        resetIn,
  input logic        readyIn,
  input logic [31:0] memAddr,
  input logic [7:0]  memOut,
  input logic        readWriteOut,
  input logic        instrOutValid,
  input logic [31:0] instrOut,
  input logic        dataOutValid,
  input logic [31:0] dataOut,
  input logic        dataWriteSuc
);

  // a load answer and a store answer never share a cycle
  answerExclusive: assert property (@(posedge clkIn) disable iff (resetIn)
    !(dataOutValid && dataWriteSuc))
    else $error("dataOutValid and dataWriteSuc high in the same cycle");

  // global stall freezes every output
  stallHolds: assert property (@(posedge clkIn) disable iff (resetIn)
    !readyIn |=> $stable({memAddr, memOut, readWriteOut, instrOutValid, instrOut,
                          dataOutValid, dataOut, dataWriteSuc}))
    else $error("an output changed while readyIn was low");

  resetQuiet: assert property (@(posedge clkIn)
    resetIn |=> !readWriteOut && !instrOutValid && !dataOutValid && !dataWriteSuc)
    else $error("a control output is high during reset");

endmodule

bind memSubsystem memSubsystemProperties i_props (
  .clkIn         (clkIn),
  .resetIn       (resetIn),
  .readyIn       (readyIn),
  .memAddr       (memAddr),
  .memOut        (memOut),
  .readWriteOut  (readWriteOut),
  .instrOutValid (instrOutValid),
  .instrOut      (instrOut),
  .dataOutValid  (dataOutValid),
  .dataOut       (dataOut),
  .dataWriteSuc  (dataWriteSuc)
);

`default_nettype wire
